//--- design/ic_cfg_pkg.sv
// ###################################################################
// Cache geometry and field widths for the instruction cache
// Power-of-two line length and line count are assumed throughout
// ###################################################################

package ic_cfg_pkg;

    // ###################################################################
    // Geometry
    // ###################################################################

    localparam int unsigned PcWidth    = 8;
    localparam int unsigned FetchWidth = 2;
    localparam int unsigned InstWidth  = 16;
    // Instructions per cache line
    localparam int unsigned LineInsts  = 4;
    localparam int unsigned NumLines   = 8;

    // PC = {tag, index, offset}
    localparam int unsigned OffsetBits = $clog2(LineInsts);
    localparam int unsigned IndexBits  = $clog2(NumLines);
    localparam int unsigned TagBits    = PcWidth - IndexBits - OffsetBits;

    // Warp shape
    localparam int unsigned WarpWidth     = 32;
    localparam int unsigned NumWarps      = 8;
    localparam int unsigned WarpIdBits    = $clog2(NumWarps);
    localparam int unsigned SubwarpIdBits = $clog2(WarpWidth);

    // ###################################################################
    // Vector types
    // ###################################################################

    typedef logic [PcWidth-1:0]              pc_t;
    typedef logic [OffsetBits-1:0]           offset_t;
    typedef logic [IndexBits-1:0]            index_t;
    typedef logic [TagBits-1:0]              tag_t;
    // Memory address of a whole line
    typedef logic [PcWidth-OffsetBits-1:0]   line_addr_t;
    typedef logic [InstWidth-1:0]            inst_t;
    // Instruction 0 sits in the low bits
    typedef logic [LineInsts*InstWidth-1:0]  line_t;
    typedef logic [FetchWidth-1:0]           fetch_mask_t;
    typedef logic [WarpWidth-1:0]            act_mask_t;
    typedef logic [WarpIdBits-1:0]           warp_id_t;
    typedef logic [SubwarpIdBits-1:0]        subwarp_id_t;

endpackage

//--- design/ic_fetch_ctrl.sv
// ###################################################################
// Fetch FSM: lookup, miss request, refill and delivery
// One memory request outstanding at most, flush served at boundaries
// ###################################################################

`timescale 1ns/1ps

module ic_fetch_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    // Fetcher side
    input  logic                   fe_valid_i,
    input  ic_msg_pkg::fetch_req_t fe_req_i,
    output logic                   ic_ready_o,
    // Decoder side
    input  logic                   dec_ready_i,
    // Memory side
    input  logic                   mem_ready_i,
    input  logic                   mem_valid_i,
    output logic                   mem_req_o,
    output ic_cfg_pkg::line_addr_t mem_addr_o,
    // Line store control
    output logic                   lookup_o,
    output logic                   refill_o,
    output logic                   flush_clear_o,
    output ic_cfg_pkg::pc_t        lookup_pc_o,
    output ic_msg_pkg::fetch_req_t active_req_o,
    input  logic                   hit_i,
    // Issue selector control
    output logic                   deliver_o
);
    import ic_cfg_pkg::*;
    import ic_msg_pkg::*;

    // ###################################################################
    // State
    // ###################################################################

    ctrl_state_e state_q, state_d;
    fetch_req_t  active_req_q;
    logic        flush_q, flush_d;

    // Handshake helpers
    logic issue_fire;
    logic boundary;
    logic accept;

    // ###################################################################
    // Handshakes
    // ###################################################################

    // Something for the decoder this cycle
    assign deliver_o = ((state_q == LOOKUP) && hit_i) || (state_q == DELIVER_REFILL);

    // Slot 0 is always valid when delivering, so deliver means a nonzero mask
    assign issue_fire = deliver_o && dec_ready_i;

    // Request boundary
    assign boundary = (state_q == IDLE) || issue_fire;

    // Pending flush takes the boundary cycle
    assign flush_clear_o = boundary && flush_q;
    assign ic_ready_o    = boundary && !flush_q;
    assign accept        = ic_ready_o && fe_valid_i;

    // Lookup straight from the fetch port
    assign lookup_o    = accept;
    assign lookup_pc_o = fe_req_i.pc;

    // Response cycle writes the line
    assign refill_o = (state_q == MISS_WAIT) && mem_valid_i;

    // Miss request held until the memory takes it
    assign mem_req_o  = (state_q == LOOKUP) && !hit_i;
    assign mem_addr_o = active_req_q.pc[PcWidth-1:OffsetBits];

    assign active_req_o = active_req_q;

    // ###################################################################
    // Next state
    // ###################################################################

    always_comb begin
        state_d = state_q;
        flush_d = flush_q;

        // Capture flush, drop it once served
        if (flush_clear_o) begin
            flush_d = 1'b0;
        end
        if (flush_i) begin
            flush_d = 1'b1;
        end

        if (boundary) begin
            // Back-to-back requests go straight into another lookup
            state_d = accept ? LOOKUP : IDLE;
        end else begin
            case (state_q)
                LOOKUP: begin
                    // Hit under back-pressure just waits here
                    if (!hit_i && mem_ready_i) begin
                        state_d = MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (mem_valid_i) begin
                        state_d = DELIVER_REFILL;
                    end
                end
                default: begin
                    // IDLE is a boundary, DELIVER_REFILL holds for the decoder
                    state_d = state_q;
                end
            endcase
        end
    end

    // ###################################################################
    // Registers
    // ###################################################################

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            flush_q <= flush_d;
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            active_req_q <= fe_req_i;
        end
    end

endmodule

//--- design/ic_issue_select.sv
// ###################################################################
// Picks the fetch-width instructions out of one cache line
// Slots past the end of the line are dropped, not fetched from the next
// ###################################################################

`timescale 1ns/1ps

module ic_issue_select (
    input  ic_msg_pkg::fetch_req_t active_req_i,
    input  ic_cfg_pkg::line_t      line_i,
    input  logic                   deliver_i,
    output ic_msg_pkg::issue_t     issue_o
);
    import ic_cfg_pkg::*;

    // Line viewed as instructions
    inst_t [LineInsts-1:0] line_insts;
    offset_t               offset;

    // Position of each slot within the line, one spare bit for overflow
    logic [FetchWidth-1:0][OffsetBits:0] slot_pos;
    fetch_mask_t                         slot_valid;

    assign line_insts = line_i;
    assign offset     = active_req_i.pc[OffsetBits-1:0];

    for (genvar k = 0; k < FetchWidth; k++) begin : gen_slot
        assign slot_pos[k]   = {1'b0, offset} + (OffsetBits + 1)'(k);
        // Inside the line and asked for
        assign slot_valid[k] = deliver_i && active_req_i.fetch_mask[k]
                               && (slot_pos[k] < (OffsetBits + 1)'(LineInsts));
    end

    always_comb begin
        issue_o       = '0;
        issue_o.valid = slot_valid;
        // Metadata only while delivering
        if (deliver_i) begin
            issue_o.req = active_req_i;
        end
        // Slot k takes the instruction at offset plus k
        for (int k = 0; k < FetchWidth; k++) begin
            if (slot_valid[k]) begin
                issue_o.inst[k] = line_insts[slot_pos[k][OffsetBits-1:0]];
            end
        end
    end

endmodule

//--- design/ic_line_ram.sv
// ###################################################################
// Single-port RAM, one cycle read latency, write-first
// Read data holds while not enabled, no reset on contents
// ###################################################################

`timescale 1ns/1ps

module ic_line_ram #(
    parameter int unsigned Width = 8
) (
    input  logic               clk_i,
    input  logic               en_i,
    input  logic               we_i,
    input  ic_cfg_pkg::index_t addr_i,
    input  logic [Width-1:0]   wdata_i,
    output logic [Width-1:0]   rdata_o
);
    import ic_cfg_pkg::*;

    // Storage array
    logic [Width-1:0] mem_q [NumLines];
    logic [Width-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
                // New data shows up on the read port
                rdata_q       <= wdata_i;
            end else begin
                rdata_q <= mem_q[addr_i];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- design/ic_line_store.sv
// ###################################################################
// Direct-mapped tag/data array with valid bits and hit compare
// Lookup and refill are never requested in the same cycle
// ###################################################################

`timescale 1ns/1ps

module ic_line_store (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              lookup_i,
    input  ic_cfg_pkg::pc_t   lookup_pc_i,
    input  logic              refill_i,
    input  ic_cfg_pkg::pc_t   active_pc_i,
    input  ic_cfg_pkg::line_t refill_line_i,
    input  logic              flush_clear_i,
    output logic              hit_o,
    output ic_cfg_pkg::line_t line_o
);
    import ic_cfg_pkg::*;

    // Address fields
    index_t lookup_idx;
    index_t active_idx;
    tag_t   active_tag;

    // RAM control
    logic   ram_en;
    index_t ram_addr;
    tag_t   stored_tag;

    // Valid bits and the one read out with the last lookup
    logic [NumLines-1:0] valid_q;
    logic                valid_rd_q;

    assign lookup_idx = lookup_pc_i[OffsetBits +: IndexBits];
    assign active_idx = active_pc_i[OffsetBits +: IndexBits];
    assign active_tag = active_pc_i[PcWidth-1 -: TagBits];

    // Only touch the RAMs on a lookup or a refill
    assign ram_en   = lookup_i | refill_i;
    assign ram_addr = refill_i ? active_idx : lookup_idx;

    ic_line_ram #(
        .Width ( TagBits )
    ) i_tag_ram (
        .clk_i   ( clk_i      ),
        .en_i    ( ram_en     ),
        .we_i    ( refill_i   ),
        .addr_i  ( ram_addr   ),
        .wdata_i ( active_tag ),
        .rdata_o ( stored_tag )
    );

    ic_line_ram #(
        .Width ( $bits(line_t) )
    ) i_data_ram (
        .clk_i   ( clk_i         ),
        .en_i    ( ram_en        ),
        .we_i    ( refill_i      ),
        .addr_i  ( ram_addr      ),
        .wdata_i ( refill_line_i ),
        .rdata_o ( line_o        )
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            // Flush wins over a refill though the two never coincide
            if (flush_clear_i) begin
                valid_q <= '0;
            end else if (refill_i) begin
                valid_q[active_idx] <= 1'b1;
            end
            // Valid bit of the looked-up line held until the next lookup
            if (lookup_i) begin
                valid_rd_q <= valid_q[lookup_idx];
            end
        end
    end

    // Stored tag against the request being served
    assign hit_o = valid_rd_q && (stored_tag == active_tag);

endmodule

//--- design/ic_msg_pkg.sv
// ###################################################################
// Fetch request and issue bundles, controller states
// Issue bundle metadata is zero whenever no slot is valid
// ###################################################################

package ic_msg_pkg;

    import ic_cfg_pkg::*;

    // ###################################################################
    // Bundles
    // ###################################################################

    // One fetch from the warp fetcher
    typedef struct packed {
        // Contiguous, bit 0 always set
        fetch_mask_t fetch_mask;
        pc_t         pc;
        act_mask_t   act_mask;
        warp_id_t    warp_id;
        subwarp_id_t subwarp_id;
    } fetch_req_t;

    // Handed to the decoder
    typedef struct packed {
        // Per-slot valid, nonzero means a transfer
        fetch_mask_t                valid;
        // Echo of the accepted request
        fetch_req_t                 req;
        // Slot k holds the instruction at offset plus k
        inst_t [FetchWidth-1:0]     inst;
    } issue_t;

    // ###################################################################
    // Controller states
    // ###################################################################

    typedef enum logic [1:0] {
        IDLE,
        // Tag and data read out, hit or miss decided here
        LOOKUP,
        // Line requested, waiting for the response
        MISS_WAIT,
        // Refilled line on the RAM read port
        DELIVER_REFILL
    } ctrl_state_e;

endpackage

//--- design/instruction_cache.sv
// ###################################################################
// Direct-mapped instruction cache, one fetcher and one memory port
// Memory response has no ready and must follow the request handshake
// ###################################################################

`timescale 1ns/1ps

module instruction_cache (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    // Fetch port
    input  logic                   fe_valid_i,
    input  ic_msg_pkg::fetch_req_t fe_req_i,
    output logic                   ic_ready_o,
    // Issue port
    output ic_msg_pkg::issue_t     issue_o,
    input  logic                   dec_ready_i,
    // Memory request
    output logic                   mem_req_o,
    output ic_cfg_pkg::line_addr_t mem_addr_o,
    input  logic                   mem_ready_i,
    // Memory response
    input  logic                   mem_valid_i,
    input  ic_cfg_pkg::line_t      mem_data_i
);
    import ic_cfg_pkg::*;
    import ic_msg_pkg::*;

    // Controller to line store
    logic       lookup;
    logic       refill;
    logic       flush_clear;
    pc_t        lookup_pc;
    fetch_req_t active_req;

    // Line store back
    logic  hit;
    line_t line;

    // Controller to issue selector
    logic deliver;

    ic_fetch_ctrl i_fetch_ctrl (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .flush_i       ( flush_i     ),
        .fe_valid_i    ( fe_valid_i  ),
        .fe_req_i      ( fe_req_i    ),
        .ic_ready_o    ( ic_ready_o  ),
        .dec_ready_i   ( dec_ready_i ),
        .mem_ready_i   ( mem_ready_i ),
        .mem_valid_i   ( mem_valid_i ),
        .mem_req_o     ( mem_req_o   ),
        .mem_addr_o    ( mem_addr_o  ),
        .lookup_o      ( lookup      ),
        .refill_o      ( refill      ),
        .flush_clear_o ( flush_clear ),
        .lookup_pc_o   ( lookup_pc   ),
        .active_req_o  ( active_req  ),
        .hit_i         ( hit         ),
        .deliver_o     ( deliver     )
    );

    ic_line_store i_line_store (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .lookup_i      ( lookup        ),
        .lookup_pc_i   ( lookup_pc     ),
        .refill_i      ( refill        ),
        .active_pc_i   ( active_req.pc ),
        .refill_line_i ( mem_data_i    ),
        .flush_clear_i ( flush_clear   ),
        .hit_o         ( hit           ),
        .line_o        ( line          )
    );

    ic_issue_select i_issue_select (
        .active_req_i ( active_req ),
        .line_i       ( line       ),
        .deliver_i    ( deliver    ),
        .issue_o      ( issue_o    )
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sim.f \
    --top-module tb_instruction_cache -o sim_tb

# The run may stop with an error, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    exit 1
fi

//--- sim.f
+incdir+tests
design/ic_cfg_pkg.sv
design/ic_msg_pkg.sv
design/ic_line_ram.sv
design/ic_line_store.sv
design/ic_fetch_ctrl.sv
design/ic_issue_select.sv
design/instruction_cache.sv
tests/tb_instruction_cache.sv

//--- tests/ic_tb_tasks.svh
// ###################################################################
// Testbench helpers for the instruction cache included in the test module
// Expects the DUT signals and the limits to be declared before it
// ###################################################################

`ifndef IC_TB_TASKS_SVH
`define IC_TB_TASKS_SVH

// ###################################################################
// Random numbers and bookkeeping
// ###################################################################

logic [31:0] lcg_state = 32'hc4fbfdf2;

// Requests seen by the memory model
int         mem_req_count = 0;
line_addr_t last_mem_addr = '0;

// Pending hit burst with the expected slot masks
fetch_req_t  burst_reqs[$];
fetch_mask_t burst_valid[$];

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// ###################################################################
// Failure reporting and compare
// ###################################################################

task automatic fail_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
    if (actual !== expected) begin
        fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                           name, actual, expected));
    end
endtask

// ###################################################################
// Line contents
// ###################################################################

// Line address in the top byte and index in the low byte
function automatic inst_t expected_inst(input line_addr_t addr, input int idx);
    return {2'b00, addr, 8'(idx)};
endfunction

function automatic line_t line_for(input line_addr_t addr);
    line_t line;
    for (int i = 0; i < LineInsts; i++) begin
        line[i*InstWidth +: InstWidth] = expected_inst(addr, i);
    end
    return line;
endfunction

// ###################################################################
// Memory model
// ###################################################################

initial begin : memory_model
    line_addr_t addr;
    int         delay;
    mem_ready_i = 1'b1;
    mem_valid_i = 1'b0;
    mem_data_i  = '0;
    forever begin
        @(negedge clk_i);
        // Handshake happens at the coming edge
        if (mem_req_o && mem_ready_i) begin
            addr          = mem_addr_o;
            last_mem_addr = addr;
            mem_req_count++;
            delay = 1 + int'((lcg_next() >> 16) % 4);
            @(posedge clk_i);
            #2;
            mem_ready_i = 1'b0;
            repeat (delay) @(posedge clk_i);
            #2;
            // One-cycle response without a ready
            mem_valid_i = 1'b1;
            mem_data_i  = line_for(addr);
            @(posedge clk_i);
            #2;
            mem_valid_i = 1'b0;
            mem_data_i  = '0;
            mem_ready_i = 1'b1;
        end
    end
end

// ###################################################################
// Drive and expect
// ###################################################################

// To the drive point after the next rising edge
task automatic step();
    @(posedge clk_i);
    #2;
endtask

function automatic fetch_req_t make_req(input pc_t pc, input fetch_mask_t mask);
    fetch_req_t  req;
    logic [31:0] r;
    req.fetch_mask = mask;
    req.pc         = pc;
    req.act_mask   = lcg_next();
    r              = lcg_next();
    req.warp_id    = r[31:29];
    req.subwarp_id = r[20:16];
    return req;
endfunction

// Holds the request until accepted and returns after the accepting edge
task automatic send_fetch(input fetch_req_t req);
    int cycles;
    cycles     = 0;
    fe_valid_i = 1'b1;
    fe_req_i   = req;
    @(negedge clk_i);
    while (!ic_ready_o) begin
        cycles++;
        if (cycles > HandshakeLimit) begin
            fail_run("Fetch request was never accepted by the cache");
        end
        @(negedge clk_i);
    end
    step();
    fe_valid_i = 1'b0;
    fe_req_i   = '0;
endtask

// Called at a negedge and returns at the negedge with a valid issue
task automatic wait_for_issue();
    int waited;
    waited = 0;
    while (issue_o.valid == '0) begin
        waited++;
        if (waited > HandshakeLimit) begin
            fail_run("No issue from the cache after a fetch");
        end
        @(negedge clk_i);
    end
endtask

task automatic check_issue(input fetch_req_t req, input fetch_mask_t exp_valid);
    inst_t exp;
    check_value("issue_o.valid", issue_o.valid, exp_valid);
    check_value("issue_o.req", issue_o.req, req);
    for (int k = 0; k < FetchWidth; k++) begin
        // Slot k is offset plus k of the same line
        exp = exp_valid[k] ? expected_inst(req.pc[PcWidth-1:OffsetBits],
                                           int'(req.pc[OffsetBits-1:0]) + k) : '0;
        check_value($sformatf("issue_o.inst[%0d]", k), issue_o.inst[k], exp);
    end
endtask

// Miss with one memory request and delivery from the refilled line
task automatic fetch_miss(input fetch_req_t req, input fetch_mask_t exp_valid);
    int count_before;
    count_before = mem_req_count;
    send_fetch(req);
    @(negedge clk_i);
    check_value("mem_req_o", mem_req_o, 1'b1);
    check_value("mem_addr_o", mem_addr_o, req.pc[PcWidth-1:OffsetBits]);
    check_value("issue_o.valid", issue_o.valid, 2'b00);
    wait_for_issue();
    check_issue(req, exp_valid);
    check_value("memory request count", mem_req_count, count_before + 1);
    step();
endtask

task automatic queue_hit(input pc_t pc, input fetch_mask_t mask,
                         input fetch_mask_t exp_valid);
    burst_reqs.push_back(make_req(pc, mask));
    burst_valid.push_back(exp_valid);
endtask

// Queued fetches back to back with each issue one cycle after acceptance
task automatic run_burst();
    int n;
    int count_before;
    n            = burst_reqs.size();
    count_before = mem_req_count;
    send_fetch(burst_reqs[0]);
    for (int i = 1; i <= n; i++) begin
        // Next request rides on the issue transfer
        if (i < n) begin
            fe_valid_i = 1'b1;
            fe_req_i   = burst_reqs[i];
        end
        @(negedge clk_i);
        check_issue(burst_reqs[i-1], burst_valid[i-1]);
        check_value("ic_ready_o", ic_ready_o, 1'b1);
        check_value("mem_req_o", mem_req_o, 1'b0);
        step();
        fe_valid_i = 1'b0;
        fe_req_i   = '0;
    end
    check_value("memory request count", mem_req_count, count_before);
    burst_reqs.delete();
    burst_valid.delete();
endtask

`endif

//--- tests/tb_instruction_cache.sv
// ###################################################################
// Directed tests for the instruction cache with a line memory model
// Memory latency is random, 1 to 4 cycles after the request
// ###################################################################

`timescale 1ns/1ps

module tb_instruction_cache;
    import ic_cfg_pkg::*;
    import ic_msg_pkg::*;

    // Run length limits
    localparam int NumTests       = 6;
    localparam int CyclesPerTest  = 200;
    localparam int HandshakeLimit = 50;

    // DUT signals
    logic       clk_i;
    logic       rst_ni;
    logic       flush_i;
    logic       fe_valid_i;
    fetch_req_t fe_req_i;
    logic       ic_ready_o;
    issue_t     issue_o;
    logic       dec_ready_i;
    logic       mem_req_o;
    line_addr_t mem_addr_o;
    logic       mem_ready_i;
    logic       mem_valid_i;
    line_t      mem_data_i;

    `include "ic_tb_tasks.svh"

    // 20 ns clock
    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    instruction_cache dut (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .flush_i     ( flush_i     ),
        .fe_valid_i  ( fe_valid_i  ),
        .fe_req_i    ( fe_req_i    ),
        .ic_ready_o  ( ic_ready_o  ),
        .issue_o     ( issue_o     ),
        .dec_ready_i ( dec_ready_i ),
        .mem_req_o   ( mem_req_o   ),
        .mem_addr_o  ( mem_addr_o  ),
        .mem_ready_i ( mem_ready_i ),
        .mem_valid_i ( mem_valid_i ),
        .mem_data_i  ( mem_data_i  )
    );

    initial begin : watchdog
        repeat (NumTests * CyclesPerTest) @(posedge clk_i);
        fail_run("Timeout: the tests did not finish in the allowed time");
    end

    // ###################################################################
    // Tests
    // ###################################################################

    task automatic test_reset_state();
        @(negedge clk_i);
        check_value("ic_ready_o", ic_ready_o, 1'b1);
        check_value("mem_req_o", mem_req_o, 1'b0);
        check_value("issue_o.valid", issue_o.valid, 2'b00);
        step();
    endtask

    task automatic test_cold_miss();
        fetch_miss(make_req(8'h14, 2'b11), 2'b11);
        check_value("memory address", last_mem_addr, 6'h05);
    endtask

    task automatic test_hits();
        // Second line at another index
        fetch_miss(make_req(8'h28, 2'b11), 2'b11);
        queue_hit(8'h15, 2'b11, 2'b11);
        queue_hit(8'h29, 2'b11, 2'b11);
        queue_hit(8'h16, 2'b11, 2'b11);
        queue_hit(8'h2a, 2'b11, 2'b11);
        queue_hit(8'h14, 2'b11, 2'b11);
        run_burst();
    endtask

    task automatic test_line_end();
        // Slot 1 would run past the line
        queue_hit(8'h17, 2'b11, 2'b01);
        queue_hit(8'h14, 2'b01, 2'b01);
        queue_hit(8'h2b, 2'b11, 2'b01);
        run_burst();
    endtask

    task automatic test_back_pressure();
        fetch_req_t req;
        issue_t     held;
        req         = make_req(8'h29, 2'b11);
        dec_ready_i = 1'b0;
        send_fetch(req);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk_i);
            if (i == 0) begin
                check_issue(req, 2'b11);
                held = issue_o;
            end
            check_value("issue_o", issue_o, held);
            check_value("ic_ready_o", ic_ready_o, 1'b0);
            step();
        end
        dec_ready_i = 1'b1;
        @(negedge clk_i);
        check_value("issue_o", issue_o, held);
        check_value("ic_ready_o", ic_ready_o, 1'b1);
        step();
        // Transferred, nothing left to issue
        @(negedge clk_i);
        check_value("issue_o.valid", issue_o.valid, 2'b00);
        step();
    endtask

    task automatic test_flush_conflict();
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        // Flush served in IDLE, fetches held off for that cycle
        @(negedge clk_i);
        check_value("ic_ready_o", ic_ready_o, 1'b0);
        step();
        fetch_miss(make_req(8'h14, 2'b11), 2'b11);
        // Index 5 with tag 1 evicts line 05
        fetch_miss(make_req(8'h34, 2'b01), 2'b01);
        fetch_miss(make_req(8'h15, 2'b11), 2'b11);
        queue_hit(8'h16, 2'b11, 2'b11);
        run_burst();
    endtask

    // ###################################################################
    // Main sequence
    // ###################################################################

    initial begin : main
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        fe_valid_i  = 1'b0;
        fe_req_i    = '0;
        dec_ready_i = 1'b1;
        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        test_reset_state();
        test_cold_miss();
        test_hits();
        test_line_end();
        test_back_pressure();
        test_flush_conflict();

        $display("Result: PASSED");
        $finish;
    end

endmodule
